// File: dcLoop_cfg.svh
`ifndef DC_LOOP_CFG_SVH
`define DC_LOOP_CFG_SVH

// Data path widths
`define DC_SAMPLE_W 16
`define DC_ERROR_W 34
`define DC_ACCUM_W 40

// Places a 16-bit sample in the top bits of the loop error
`define DC_ERR_SHIFT 18

// Register values after reset
`define DC_LAGEXP_RESET 5'd12
`define DC_LIMIT_RESET 32'h7FFF_0000

`endif

// File: dcLoopPkg.sv
`default_nettype none

`include "dcLoop_cfg.svh"

package dcLoopPkg;

    // Host command opcodes
    typedef enum logic [1:0] {
        OP_SET_LAGEXP = 2'd0,
        OP_SET_LIMIT  = 2'd1,
        OP_CLEAR      = 2'd2,
        OP_READ_ACCUM = 2'd3
    } hostOp_t;

    typedef struct packed {
        hostOp_t     op;
        logic [31:0] operand;   // lagExp in the low 5 bits, or the full limit
    } hostCmd_t;

    typedef struct packed {
        logic [`DC_ACCUM_W-1:0] readData;
    } hostRsp_t;

    // Four-phase handshake states of the register block
    typedef enum logic [1:0] {
        HS_IDLE      = 2'd0,
        HS_ACK       = 2'd1,
        HS_WAIT_DROP = 2'd2
    } hsState_t;

    typedef struct packed {
        logic [4:0]  lagExp;
        logic [31:0] limit;      // Symmetric clamp, compared against accum[39:8]
        logic        clearAccum; // One-cycle pulse
    } loopCfg_t;

endpackage

`default_nettype wire

// File: dcLoopRegs.sv
`timescale 1ns/10ps
`default_nettype none

`include "dcLoop_cfg.svh"

module dcLoopRegs (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req,
    input  dcLoopPkg::hostCmd_t    cmd,
    output logic                   ack,
    output dcLoopPkg::hostRsp_t    rsp,
    input  logic [`DC_ACCUM_W-1:0] lagAccum,
    output dcLoopPkg::loopCfg_t    cfg
);

    dcLoopPkg::hsState_t state;
    logic [4:0]          lagExp;
    logic [31:0]         limit;
    logic                clearPulse;
    logic                startCmd;

    // A command is performed only on the IDLE to ACK step
    assign startCmd = (state == dcLoopPkg::HS_IDLE) && req;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= dcLoopPkg::HS_IDLE;
        end else begin
            case (state)
                dcLoopPkg::HS_IDLE: begin
                    if (req)
                        state <= dcLoopPkg::HS_ACK;
                end
                dcLoopPkg::HS_ACK: begin
                    state <= req ? dcLoopPkg::HS_WAIT_DROP : dcLoopPkg::HS_IDLE;
                end
                dcLoopPkg::HS_WAIT_DROP: begin
                    if (!req)
                        state <= dcLoopPkg::HS_IDLE; // ack falls one cycle after req
                end
                default: state <= dcLoopPkg::HS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lagExp     <= `DC_LAGEXP_RESET;
            limit      <= `DC_LIMIT_RESET;
            clearPulse <= 1'b0;
            rsp        <= '0;
        end else begin
            clearPulse <= 1'b0;
            if (startCmd) begin
                case (cmd.op)
                    dcLoopPkg::OP_SET_LAGEXP: lagExp <= cmd.operand[4:0];
                    dcLoopPkg::OP_SET_LIMIT:  limit <= cmd.operand;
                    dcLoopPkg::OP_CLEAR:      clearPulse <= 1'b1; // High during HS_ACK
                    dcLoopPkg::OP_READ_ACCUM: rsp.readData <= lagAccum;
                endcase
            end
        end
    end

    assign ack = (state != dcLoopPkg::HS_IDLE);

    assign cfg.lagExp     = lagExp;
    assign cfg.limit      = limit;
    assign cfg.clearAccum = clearPulse;

endmodule

`default_nettype wire

// File: dcErrorDetect.sv
`timescale 1ns/10ps
`default_nettype none

`include "dcLoop_cfg.svh"

module dcErrorDetect (
    input  logic                           clk,
    input  logic                           reset,
    input  logic signed [`DC_SAMPLE_W-1:0] sampleIn,
    input  logic                           sampleValid,
    input  logic [`DC_ACCUM_W-1:0]         lagAccum,
    output logic signed [`DC_SAMPLE_W-1:0] corrected,
    output logic                           correctedValid,
    output logic [`DC_ERROR_W-1:0]         loopError
);

    localparam int ErrW = `DC_ERROR_W;

    logic signed [`DC_SAMPLE_W-1:0] dcEstimate;
    logic signed [ErrW-1:0]         errExt;

    // Top accumulator bits hold the DC estimate in sample units
    assign dcEstimate = lagAccum[`DC_ACCUM_W-1 -: `DC_SAMPLE_W];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            corrected      <= '0;
            correctedValid <= 1'b0;
        end else begin
            correctedValid <= sampleValid;
            if (sampleValid)
                corrected <= sampleIn - dcEstimate; // Wraps in 16 bits
        end
    end

    // Sign extend, then align so the lag exponent table
    // sees the sample in error[33:18]
    assign errExt    = corrected;
    assign loopError = errExt <<< `DC_ERR_SHIFT;

endmodule

`default_nettype wire

// File: dcLoopFilter.sv
`timescale 1ns/10ps
`default_nettype none

`include "dcLoop_cfg.svh"

module dcLoopFilter (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   clkEn,
    input  logic [`DC_ERROR_W-1:0] error,
    input  dcLoopPkg::loopCfg_t    cfg,
    output logic [`DC_ACCUM_W-1:0] lagAccum
);

    // lagExp at which the error enters the accumulator unshifted
    localparam logic [4:0] UnityExp = 5'd25;

    logic signed [`DC_ACCUM_W-1:0] errWide;
    logic signed [`DC_ACCUM_W-1:0] lagError;
    logic [4:0]                    rightAmt;
    logic [4:0]                    leftAmt;
    logic [31:0]                   upperLimit;
    logic [31:0]                   lowerLimit;
    logic [`DC_ACCUM_W-1:0]        sum;

    assign errWide  = {{(`DC_ACCUM_W - `DC_ERROR_W){error[`DC_ERROR_W-1]}}, error};
    assign rightAmt = UnityExp - cfg.lagExp;
    assign leftAmt  = cfg.lagExp - UnityExp;

    // Lag gain, one bit of gain per lagExp step
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lagError <= '0;
        end else if (cfg.clearAccum) begin
            lagError <= '0;
        end else if (clkEn) begin
            if (cfg.lagExp == 5'd0)
                lagError <= '0;                   // Loop frozen
            else if (cfg.lagExp <= UnityExp)
                lagError <= errWide >>> rightAmt;
            else
                lagError <= errWide <<< leftAmt;
        end
    end

    assign upperLimit = cfg.limit;
    assign lowerLimit = -cfg.limit;
    assign sum        = lagAccum + lagError;

    // Accumulator with symmetric clamp on the top 32 bits
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lagAccum <= '0;
        end else if (cfg.clearAccum) begin
            lagAccum <= '0;
        end else if (clkEn) begin
            if (!sum[`DC_ACCUM_W-1] && (sum[`DC_ACCUM_W-1:8] >= upperLimit)) begin
                lagAccum <= {upperLimit, 8'h00};
            end else if (sum[`DC_ACCUM_W-1] && (sum[`DC_ACCUM_W-1:8] < lowerLimit)) begin
                lagAccum <= {lowerLimit, 8'hFF};
            end else begin
                lagAccum <= sum;
            end
        end
    end

endmodule

`default_nettype wire

// File: dcCanceller.sv
`timescale 1ns/10ps
`default_nettype none

`include "dcLoop_cfg.svh"

module dcCanceller (
    input  logic                           clk,
    input  logic                           reset,
    input  logic signed [`DC_SAMPLE_W-1:0] sampleIn,
    input  logic                           sampleValid,
    output logic signed [`DC_SAMPLE_W-1:0] corrected,
    output logic                           correctedValid,
    input  logic                           req,
    input  dcLoopPkg::hostCmd_t            cmd,
    output logic                           ack,
    output dcLoopPkg::hostRsp_t            rsp
);

    logic [`DC_ACCUM_W-1:0] lagAccum;   // Loop state, also the DC estimate source
    logic [`DC_ERROR_W-1:0] loopError;
    dcLoopPkg::loopCfg_t    cfg;

    dcLoopRegs regs (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .cmd      (cmd),
        .ack      (ack),
        .rsp      (rsp),
        .lagAccum (lagAccum),
        .cfg      (cfg)
    );

    dcErrorDetect errDet (
        .clk            (clk),
        .reset          (reset),
        .sampleIn       (sampleIn),
        .sampleValid    (sampleValid),
        .lagAccum       (lagAccum),
        .corrected      (corrected),
        .correctedValid (correctedValid),
        .loopError      (loopError)
    );

    // Filter steps once per corrected sample
    dcLoopFilter loopFilt (
        .clk      (clk),
        .reset    (reset),
        .clkEn    (correctedValid),
        .error    (loopError),
        .cfg      (cfg),
        .lagAccum (lagAccum)
    );

endmodule

`default_nettype wire

// File: tb_dcCanceller.sv
`timescale 1ns/10ps
`default_nettype none

`include "dcLoop_cfg.svh"

module tb_dcCanceller;

    localparam int AckTimeout   = 16;
    localparam int DrainTimeout = 32;

    logic                           clk;
    logic                           reset;
    logic signed [`DC_SAMPLE_W-1:0] sampleIn;
    logic                           sampleValid;
    logic signed [`DC_SAMPLE_W-1:0] corrected;
    logic                           correctedValid;
    logic                           req;
    dcLoopPkg::hostCmd_t            cmd;
    logic                           ack;
    dcLoopPkg::hostRsp_t            rsp;

    logic [15:0]                    lfsrState = 16'd25006;
    logic                           strobeSeen = 1'b0;  // sampleValid of the cycle just ended
    logic signed [`DC_SAMPLE_W-1:0] expQ[$];    // Corrected values still in flight
    string                          nameQ[$];

    dcCanceller UUT (
        .clk            (clk),
        .reset          (reset),
        .sampleIn       (sampleIn),
        .sampleValid    (sampleValid),
        .corrected      (corrected),
        .correctedValid (correctedValid),
        .req            (req),
        .cmd            (cmd),
        .ack            (ack),
        .rsp            (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic failRun(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1, "first error, run stopped");
    endtask

    task automatic checkCorrected(input string name, input logic signed [`DC_SAMPLE_W-1:0] exp,
                                  input logic signed [`DC_SAMPLE_W-1:0] act);
        if (act !== exp)
            failRun($sformatf("ERR %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic checkRsp(input string name, input dcLoopPkg::hostRsp_t exp,
                            input dcLoopPkg::hostRsp_t act);
        if (act !== exp)
            failRun($sformatf("ERR %s expected %h actual %h", name, exp.readData, act.readData));
    endtask

    task automatic checkAck(input string name, input logic exp, input logic act);
        if (act !== exp)
            failRun($sformatf("ERR %s expected ack %b actual %b", name, exp, act));
    endtask

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic drawGap(output int gap);
        gap = 0;
        repeat (2) begin
            lfsrState = lfsrNext(lfsrState);
            gap = (gap << 1) | int'(lfsrState[0]);
        end
    endtask

    task automatic sendSample(input string name, input logic [15:0] value,
                              input logic gapAllowed, input logic [15:0] expValue);
        int gap;
        gap = 0;
        if (gapAllowed)
            drawGap(gap);
        repeat (gap) begin
            @(posedge clk);
            sampleValid <= 1'b0;
        end
        @(posedge clk);
        sampleIn    <= value;
        sampleValid <= 1'b1;
        expQ.push_back(expValue);
        nameQ.push_back(name);
    endtask

    task automatic sendCommand(input string name, input dcLoopPkg::hostOp_t op,
                               input logic [31:0] operand, input logic [39:0] expData);
        dcLoopPkg::hostRsp_t expRsp;
        int                  cycles;
        expRsp.readData = expData;
        @(posedge clk);
        sampleValid <= 1'b0;
        repeat (2) @(posedge clk);  // Filter takes the last strobe first
        cmd.op      <= op;
        cmd.operand <= operand;
        req         <= 1'b1;
        @(negedge clk);
        checkAck({name, " before ack"}, 1'b0, ack);  // ack follows req by one cycle
        cycles = 1;
        while (ack !== 1'b1) begin
            if (cycles >= AckTimeout)
                failRun($sformatf("timeout: ack never rose for command %s", name));
            @(negedge clk);
            cycles++;
        end
        if (op == dcLoopPkg::OP_READ_ACCUM)
            checkRsp(name, expRsp, rsp);
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        checkAck({name, " after drop"}, 1'b1, ack);
        cycles = 1;
        while (ack !== 1'b0) begin
            if (cycles >= AckTimeout)
                failRun($sformatf("timeout: ack stayed high after req dropped for %s", name));
            @(negedge clk);
            cycles++;
        end
    endtask

    always @(posedge clk)
        strobeSeen <= sampleValid;

    // Each strobe gives exactly one corrected output in the next cycle
    always @(negedge clk) begin
        if (reset === 1'b0) begin
            if (strobeSeen && correctedValid !== 1'b1)
                failRun("correctedValid did not rise one cycle after a sample strobe");
            else if (!strobeSeen && correctedValid !== 1'b0)
                failRun("correctedValid high without a sample strobe in the cycle before");
            else if (strobeSeen)
                checkCorrected(nameQ.pop_front(), expQ.pop_front(), corrected);
        end
    end

    initial begin
        int          fd;
        int          lineNo;
        int          fields;
        int          cycles;
        string       line;
        string       kind;
        string       tag;
        logic [31:0] value;
        logic [31:0] operand;
        logic [39:0] expected;
        reset       = 1'b1;
        sampleIn    = '0;
        sampleValid = 1'b0;
        req         = 1'b0;
        cmd         = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            checkAck("idle after reset", 1'b0, ack);
        end
        fd = $fopen("dcCanceller_golden.txt", "r");
        if (fd == 0)
            failRun("could not open dcCanceller_golden.txt");
        lineNo = 0;
        while ($fgets(line, fd) != 0) begin
            lineNo++;
            if (line.len() < 2 || line.getc(0) == "#")
                continue;
            fields = $sscanf(line, "%s %s %h %h %h", kind, tag, value, operand, expected);
            if (fields != 5)
                failRun($sformatf("golden line %0d could not be parsed", lineNo));
            tag = $sformatf("%s@%0d", tag, lineNo);
            if (kind == "CMD")
                sendCommand(tag, dcLoopPkg::hostOp_t'(value[1:0]), operand, expected);
            else if (kind == "SAMPLE")
                sendSample(tag, value[15:0], operand[0], expected[15:0]);
            else
                failRun($sformatf("golden line %0d has unknown kind %s", lineNo, kind));
        end
        $fclose(fd);
        @(posedge clk);
        sampleValid <= 1'b0;
        cycles = 0;
        while (expQ.size() != 0) begin
            if (cycles >= DrainTimeout)
                failRun("timeout: corrected outputs missing at end of stimulus");
            @(posedge clk);
            cycles++;
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: dcCanceller_golden.txt
# kind tag value operand expected (value, operand, expected in hex)
# CMD: value = opcode, expected = readback; SAMPLE: operand 1 = random gap allowed
CMD    setLagZero   0 00000000 0000000000
SAMPLE frozenRaw    03E8 1 03E8
SAMPLE frozenRaw    03E8 1 03E8
SAMPLE frozenRaw    03E8 1 03E8
SAMPLE frozenRaw    03E8 1 03E8
CMD    setLagFast   0 0000001D 0000000000
SAMPLE converge     03E8 0 03E8
SAMPLE converge     03E8 0 03E8
SAMPLE converge     03E8 0 03E8
SAMPLE converge     03E8 0 02EE
SAMPLE converge     03E8 0 01F4
SAMPLE converge     03E8 0 00FA
SAMPLE converge     03E8 0 003F
SAMPLE converge     03E8 0 FFC2
SAMPLE converge     03E8 0 FF83
SAMPLE converge     03E8 0 FF74
SAMPLE converge     03E8 0 FF83
SAMPLE converge     03E8 0 FFA2
SAMPLE converge     03E8 0 FFC5
SAMPLE converge     03E8 0 FFE5
SAMPLE converge     03E8 0 FFFC
SAMPLE converge     03E8 0 000B
CMD    readConverge 3 00000000 03D5C00000
CMD    freezeLoop   0 00000000 0000000000
SAMPLE flushLag     03E8 1 0013
CMD    readHeld     3 00000000 03D8800000
SAMPLE heldEst      03E8 1 0010
SAMPLE heldEst      07D0 1 03F8
SAMPLE heldEst      FE0C 1 FA34
SAMPLE heldEst      0000 1 FC28
CMD    readHeldAgain 3 00000000 03D8800000
CMD    setLagClamp  0 0000001D 0000000000
CMD    setLimit     1 00010000 0000000000
CMD    clearPos     2 00000000 0000000000
CMD    readCleared  3 00000000 0000000000
SAMPLE clampPos     7530 0 7530
SAMPLE clampPos     7530 0 7530
SAMPLE clampPos     7530 0 7530
SAMPLE clampPos     7530 0 752F
SAMPLE clampPos     7530 0 752F
CMD    readPosLimit 3 00000000 0001000000
CMD    clearNeg     2 00000000 0000000000
CMD    readCleared  3 00000000 0000000000
SAMPLE clampNeg     8AD0 0 8AD0
SAMPLE clampNeg     8AD0 0 8AD0
SAMPLE clampNeg     8AD0 0 8AD0
SAMPLE clampNeg     8AD0 0 8AD1
SAMPLE clampNeg     8AD0 0 8AD1
CMD    readNegLimit 3 00000000 FFFF0000FF

// File: files.f
+incdir+.
dcLoopPkg.sv
dcLoopRegs.sv
dcErrorDetect.sv
dcLoopFilter.sv
dcCanceller.sv
tb_dcCanceller.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the DC canceller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_dcCanceller \
    -f files.f -o tb_dcCanceller

./obj_dir/tb_dcCanceller > sim.log 2>&1 || true
cat sim.log

if grep -q "^sim passed" sim.log; then
    exit 0
fi
exit 1
